//--- Bender.yml
package:
  name: wh_io_fabric

sources:
  - files:
      - hw/wh_pkg.sv
      - hw/wh_credit_fifo.sv
      - hw/wh_router.sv
      - hw/wh_concentrator.sv
      - hw/wh_io_fabric.sv
  - target: test
    files:
      - dv/wh_clk_gen.sv
      - dv/wh_io_fabric_props.sv
      - dv/wh_io_fabric_tb.sv

//--- dv/wh_clk_gen.sv
`timescale 1ns/100ps

module wh_clk_gen #(
  parameter int PERIOD_NS = 40
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

endmodule

//--- dv/wh_io_fabric_props.sv
`timescale 1ns/100ps

module wh_io_fabric_props (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  wh_pkg::wh_link_t mem_north_link_i,
  input  logic             mem_north_credit_i,
  input  wh_pkg::wh_link_t mem_south_link_i,
  input  logic             mem_south_credit_i,
  input  wh_pkg::wh_link_t io_link_i,
  input  logic             io_credit_i,
  input  logic             north_credit_i,
  input  logic             south_credit_i,
  input  logic [1:0]       ctr_pop_i
);
  import wh_pkg::*;

  logic [2:0]           out_v;
  logic [2:0]           ret;
  wh_credit_cnt_t [2:0] in_flight_q;  // 0 mem north, 1 mem south, 2 io
  wh_header_t           io_hdr;
  wh_len_t              io_rem_q;     // body flits still due on io_link_o
  wh_cid_t              io_owner_q;

  assign out_v  = {io_link_i.v, mem_south_link_i.v, mem_north_link_i.v};
  assign ret    = {io_credit_i, mem_south_credit_i, mem_north_credit_i};
  assign io_hdr = wh_header_t'(io_link_i.data);

  // flits seen on each output port and not yet credited back
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      in_flight_q <= '0;
    end else begin
      for (int i = 0; i < 3; i++) begin
        in_flight_q[i] <= in_flight_q[i] + wh_credit_cnt_t'(out_v[i])
                          - wh_credit_cnt_t'(ret[i]);
      end
    end
  end

  // packet framing as seen on io_link_o
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      io_rem_q   <= '0;
      io_owner_q <= '0;
    end else if (io_link_i.v) begin
      if (io_rem_q == '0) begin
        io_rem_q   <= io_hdr.len;
        io_owner_q <= io_hdr.cid;
      end else begin
        io_rem_q <= io_rem_q - 1'b1;
      end
    end
  end

  mem_north_credit_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_north_link_i.v |-> in_flight_q[0] < WH_FIFO_DEPTH)
    else $error("mem_north_link_o valid sent without credit");

  mem_south_credit_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_south_link_i.v |-> in_flight_q[1] < WH_FIFO_DEPTH)
    else $error("mem_south_link_o valid sent without credit");

  io_credit_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    io_link_i.v |-> in_flight_q[2] < WH_FIFO_DEPTH)
    else $error("io_link_o valid sent without credit");

  reset_credit_a: assert property (@(posedge clk_i)
    !rst_n_i |-> !north_credit_i && !south_credit_i)
    else $error("credit output high during reset");

  // every body flit leaving on io was dequeued from its header's source
  no_interleave_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    io_link_i.v && io_rem_q != '0 |-> $past(ctr_pop_i) == (2'b01 << io_owner_q))
    else $error("concentrator popped another input inside a packet");

endmodule

bind wh_io_fabric wh_io_fabric_props props (
  .clk_i(clk_i)
  ,.rst_n_i(rst_n_i)
  ,.mem_north_link_i(mem_north_link_o)
  ,.mem_north_credit_i(mem_north_credit_i)
  ,.mem_south_link_i(mem_south_link_o)
  ,.mem_south_credit_i(mem_south_credit_i)
  ,.io_link_i(io_link_o)
  ,.io_credit_i(io_credit_i)
  ,.north_credit_i(north_credit_o)
  ,.south_credit_i(south_credit_o)
  ,.ctr_pop_i(ctr.pop_in)
);

//--- dv/wh_io_fabric_tb.sv
`timescale 1ns/100ps

module wh_io_fabric_tb;
  import wh_pkg::*;

  typedef wh_flit_t flit_q_t[$];

  localparam int CLK_PERIOD   = 40;
  localparam int DRIVE_SKEW   = 2;
  localparam int TOTAL_FLITS  = 35;  // all four tests
  localparam int WAIT_LIMIT   = 60;
  localparam int QUIET_CYCLES = 4;   // unloaded IO latency
  localparam int WATCHDOG_NS  = 5 * TOTAL_FLITS * CLK_PERIOD + 2000;

  logic       clk;
  logic       rst_n;
  wh_link_t   north_link;
  wh_link_t   south_link;
  logic       north_credit;
  logic       south_credit;
  wh_link_t   mem_north_link;
  wh_link_t   mem_south_link;
  wh_link_t   io_link;
  logic       mem_north_credit;
  logic       mem_south_credit;
  logic       io_credit;
  int         seed = 32'h02a63497;
  int         errors;
  int         err_start;
  int         tests;
  int         sent [2];
  int         returned [2];
  int         pend [3];  // 0 mem north, 1 mem south, 2 io
  logic [2:0] hold;
  wh_flit_t   mem_north_q[$];
  wh_flit_t   mem_south_q[$];
  wh_flit_t   io_q[$];

  wh_clk_gen #(.PERIOD_NS(CLK_PERIOD)) clk_gen (.clk_o(clk));

  wh_io_fabric dut_i (
    .clk_i(clk)
    ,.rst_n_i(rst_n)
    ,.north_link_i(north_link)
    ,.north_credit_o(north_credit)
    ,.south_link_i(south_link)
    ,.south_credit_o(south_credit)
    ,.mem_north_link_o(mem_north_link)
    ,.mem_north_credit_i(mem_north_credit)
    ,.mem_south_link_o(mem_south_link)
    ,.mem_south_credit_i(mem_south_credit)
    ,.io_link_o(io_link)
    ,.io_credit_i(io_credit)
  );

  always @(posedge clk) begin
    if (north_credit) returned[0]++;
    if (south_credit) returned[1]++;
  end

  // memory and IO sinks, one credit back per cycle unless held
  always @(posedge clk) begin
    logic [2:0] rel;
    if (mem_north_link.v) begin
      mem_north_q.push_back(mem_north_link.data);
      pend[0]++;
    end
    if (mem_south_link.v) begin
      mem_south_q.push_back(mem_south_link.data);
      pend[1]++;
    end
    if (io_link.v) begin
      io_q.push_back(io_link.data);
      pend[2]++;
    end
    for (int s = 0; s < 3; s++) begin
      rel[s] = (pend[s] > 0) && !hold[s];
      if (rel[s]) pend[s]--;
    end
    #(DRIVE_SKEW);
    {io_credit, mem_south_credit, mem_north_credit} = rel;
  end

  function automatic wh_credit_cnt_t credits(input int src);
    return wh_credit_cnt_t'(WH_FIFO_DEPTH - (sent[src] - returned[src]));
  endfunction

  function automatic flit_q_t make_pkt(input wh_cord_t cord, input wh_len_t len);
    flit_q_t    pkt;
    wh_header_t hdr;
    hdr.payload = WH_PAYLOAD_W'($random(seed));
    hdr.cid     = wh_cid_t'($random(seed));
    hdr.len     = len;
    hdr.cord    = cord;
    pkt.push_back(wh_flit_t'(hdr));
    for (int k = 0; k < int'(len); k++)
      pkt.push_back(wh_flit_t'($random(seed)));
    return pkt;
  endfunction

  // packet copy with the header cid replaced
  function automatic flit_q_t to_io(input flit_q_t pkt, input wh_cid_t src);
    wh_header_t hdr;
    hdr     = wh_header_t'(pkt[0]);
    hdr.cid = src;
    pkt[0]  = wh_flit_t'(hdr);
    return pkt;
  endfunction

  task automatic check_flit(input string name, input wh_flit_t got, input wh_flit_t exp);
    if (got !== exp) begin
      $display("Error: %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input wh_credit_cnt_t got,
                             input wh_credit_cnt_t exp);
    if (got !== exp) begin
      $display("Error: %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_pkt(input string name, input flit_q_t got, input int first,
                           input flit_q_t exp);
    foreach (exp[k]) check_flit(name, got[first + k], exp[k]);
  endtask

  task automatic check_size(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("%s carried %0d flits where %0d were expected", name, got, exp);
      errors++;
    end
  endtask

  task automatic drive_link(input int src, input wh_link_t lnk);
    if (src == 0) north_link = lnk;
    else south_link = lnk;
  endtask

  task automatic send_pkt(input int src, input flit_q_t pkt);
    wh_link_t lnk;
    foreach (pkt[k]) begin
      while (credits(src) == '0) begin
        drive_link(src, '0);
        @(posedge clk);
        #(DRIVE_SKEW);
      end
      lnk.v    = 1'b1;
      lnk.data = pkt[k];
      drive_link(src, lnk);
      sent[src]++;
      @(posedge clk);
      #(DRIVE_SKEW);
    end
    drive_link(src, '0);
  endtask

  task automatic wait_rx(input int n);
    int cycles;
    cycles = 0;
    while (mem_north_q.size() + mem_south_q.size() + io_q.size() < n
           && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      #(DRIVE_SKEW);
      cycles++;
    end
    if (cycles == WAIT_LIMIT) begin
      $display("sinks did not receive %0d flits in time", n);
      errors++;
    end
  endtask

  // credits home, sinks empty and outputs idle for a few cycles
  task automatic wait_drain;
    int cycles;
    int quiet;
    cycles = 0;
    quiet  = 0;
    while (quiet < QUIET_CYCLES && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      #(DRIVE_SKEW);
      cycles++;
      if (credits(0) == WH_FIFO_DEPTH && credits(1) == WH_FIFO_DEPTH
          && pend[0] + pend[1] + pend[2] == 0
          && !(mem_north_link.v || mem_south_link.v || io_link.v)) quiet++;
      else quiet = 0;
    end
    if (quiet < QUIET_CYCLES) begin
      $display("fabric did not drain, credits or flits still outstanding");
      errors++;
    end
    check_count("north_credit_o returns", credits(0), wh_credit_cnt_t'(WH_FIFO_DEPTH));
    check_count("south_credit_o returns", credits(1), wh_credit_cnt_t'(WH_FIFO_DEPTH));
  endtask

  task automatic start_test;
    mem_north_q.delete();
    mem_south_q.delete();
    io_q.delete();
    err_start = errors;
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0s finished with %0d errors", name, errors - err_start);
  endtask

  task automatic test_mem_route;
    flit_q_t pkt;
    start_test();
    pkt = make_pkt(4'h3, 3'd4);
    send_pkt(0, pkt);
    wait_rx(pkt.size());
    wait_drain();
    check_pkt("mem_north_link_o", mem_north_q, 0, pkt);
    check_size("mem_north_link_o", mem_north_q.size(), pkt.size());
    check_size("mem_south_link_o", mem_south_q.size(), 0);
    check_size("io_link_o", io_q.size(), 0);
    end_test("mem_route");
  endtask

  task automatic test_io_cid;
    flit_q_t pn;
    flit_q_t ps;
    start_test();
    ps = to_io(make_pkt(WH_IO_CORD, 3'd2), 1'b0);  // enters with the other cid
    pn = to_io(make_pkt(WH_IO_CORD, 3'd2), 1'b1);
    send_pkt(1, ps);
    send_pkt(0, pn);
    wait_rx(ps.size() + pn.size());
    wait_drain();
    check_pkt("io_link_o", io_q, 0, to_io(ps, 1'b1));
    check_pkt("io_link_o", io_q, ps.size(), to_io(pn, 1'b0));
    check_size("io_link_o", io_q.size(), ps.size() + pn.size());
    check_size("mem_north_link_o", mem_north_q.size(), 0);
    check_size("mem_south_link_o", mem_south_q.size(), 0);
    end_test("io_cid");
  endtask

  task automatic test_io_contention;
    flit_q_t    pn;
    flit_q_t    ps;
    wh_header_t hdr [2];
    start_test();
    pn = to_io(make_pkt(WH_IO_CORD, 3'd3), 1'b1);
    ps = to_io(make_pkt(WH_IO_CORD, 3'd3), 1'b0);
    fork
      send_pkt(0, pn);
      send_pkt(1, ps);
    join
    wait_rx(8);
    wait_drain();
    check_size("io_link_o", io_q.size(), 8);
    for (int p = 0; p < 2; p++) begin
      hdr[p] = wh_header_t'(io_q[4 * p]);
      if (hdr[p].cid == 1'b1) check_pkt("io_link_o", io_q, 4 * p, to_io(ps, 1'b1));
      else check_pkt("io_link_o", io_q, 4 * p, to_io(pn, 1'b0));
    end
    if (hdr[0].cid == hdr[1].cid) begin
      $display("both IO packets name the same source %0d", hdr[0].cid);
      errors++;
    end
    end_test("io_contention");
  endtask

  task automatic test_backpressure;
    flit_q_t p0;
    flit_q_t p1;
    int      sent_start;
    start_test();
    p0 = make_pkt(4'h2, 3'd7);
    p1 = make_pkt(4'h5, 3'd7);
    sent_start = sent[1];
    hold[1] = 1'b1;
    fork
      begin
        send_pkt(1, p0);
        send_pkt(1, p1);
      end
      begin
        wait_rx(WH_FIFO_DEPTH);
        repeat (10) @(posedge clk);  // give extra flits a chance to leak
        #(DRIVE_SKEW);
        check_size("mem_south_link_o while held", mem_south_q.size(), WH_FIFO_DEPTH);
        check_count("south sender credits while held", credits(1), '0);
        if (sent[1] - sent_start != 2 * WH_FIFO_DEPTH) begin
          $display("south sender pushed %0d flits into the held path", sent[1] - sent_start);
          errors++;
        end
        hold[1] = 1'b0;
      end
    join
    wait_rx(p0.size() + p1.size());
    wait_drain();
    check_pkt("mem_south_link_o", mem_south_q, 0, p0);
    check_pkt("mem_south_link_o", mem_south_q, p0.size(), p1);
    check_size("mem_south_link_o", mem_south_q.size(), p0.size() + p1.size());
    check_size("io_link_o", io_q.size(), 0);
    end_test("backpressure");
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired at %0t, tests did not complete", $time);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    rst_n            = 1'b0;
    north_link       = '0;
    south_link       = '0;
    mem_north_credit = 1'b0;
    mem_south_credit = 1'b0;
    io_credit        = 1'b0;
    hold             = '0;
    errors           = 0;
    tests            = 0;
    sent             = '{0, 0};
    returned         = '{0, 0};
    pend             = '{0, 0, 0};
    repeat (3) @(posedge clk);
    #(DRIVE_SKEW);
    rst_n = 1'b1;
    test_mem_route();
    test_io_cid();
    test_io_contention();
    test_backpressure();
    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- hw/wh_concentrator.sv
`timescale 1ns/100ps

module wh_concentrator (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  wh_pkg::wh_link_t [1:0] link_i,
  output logic [1:0]             credit_o,
  output wh_pkg::wh_link_t       io_link_o,
  input  logic                   io_credit_i
);
  import wh_pkg::*;

  wh_flit_t [1:0]  head;
  logic [1:0]      head_v;
  logic [1:0]      pop_in;
  logic            pop;
  wh_cid_t         last_q;      // last winner, also the grant held through the body
  wh_cid_t         pref;
  wh_cid_t         grant;
  wh_route_state_e state_q;
  wh_len_t         body_cnt_q;
  wh_header_t      hdr;
  wh_header_t      stamped;
  wh_flit_t        out_next;
  wh_credit_cnt_t  cnt_q;
  logic            out_v_q;
  wh_flit_t        out_q;

  for (genvar i = 0; i < 2; i++) begin : g_in
    wh_credit_fifo fifo (
      .clk_i(clk_i)
      ,.rst_n_i(rst_n_i)
      ,.link_i(link_i[i])
      ,.credit_o(credit_o[i])
      ,.head_o(head[i])
      ,.head_v_o(head_v[i])
      ,.pop_i(pop_in[i])
    );
  end

  // round robin, input after the last winner first
  assign pref   = ~last_q;
  assign grant  = (state_q == WH_BODY) ? last_q : (head_v[pref] ? pref : last_q);
  assign pop    = head_v[grant] && (cnt_q != '0);
  assign pop_in = pop ? (2'b01 << grant) : 2'b00;
  assign hdr    = wh_header_t'(head[grant]);

  always_comb begin
    stamped     = hdr;
    stamped.cid = grant;  // source index for the IO side
  end

  assign out_next = (state_q == WH_IDLE) ? wh_flit_t'(stamped) : head[grant];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= WH_IDLE;
      last_q     <= wh_cid_t'(1);  // input 0 wins first
      body_cnt_q <= '0;
    end else if (pop) begin
      if (state_q == WH_IDLE) begin
        last_q     <= grant;
        body_cnt_q <= hdr.len;
        if (hdr.len != '0) begin
          state_q <= WH_BODY;
        end
      end else begin
        body_cnt_q <= body_cnt_q - 1'b1;
        if (body_cnt_q == wh_len_t'(1)) begin
          state_q <= WH_IDLE;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q   <= wh_credit_cnt_t'(WH_FIFO_DEPTH);
      out_v_q <= 1'b0;
    end else begin
      cnt_q   <= cnt_q + wh_credit_cnt_t'(io_credit_i) - wh_credit_cnt_t'(pop);
      out_v_q <= pop;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop) begin
      out_q <= out_next;
    end
  end

  assign io_link_o.v    = out_v_q;
  assign io_link_o.data = out_q;

endmodule

//--- hw/wh_credit_fifo.sv
`timescale 1ns/100ps

module wh_credit_fifo (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  wh_pkg::wh_link_t link_i,
  output logic             credit_o,
  output wh_pkg::wh_flit_t head_o,
  output logic             head_v_o,
  input  logic             pop_i
);
  import wh_pkg::*;

  wh_flit_t       mem_q [WH_FIFO_DEPTH];
  wh_ptr_t        wr_ptr_q;
  wh_ptr_t        rd_ptr_q;
  wh_credit_cnt_t count_q;
  logic           credit_q;

  // storage, no reset needed
  always_ff @(posedge clk_i) begin
    if (link_i.v) begin
      mem_q[wr_ptr_q] <= link_i.data;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (link_i.v) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;  // depth is a power of two
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + wh_credit_cnt_t'(link_i.v) - wh_credit_cnt_t'(pop_i);
    end
  end

  // one credit per dequeued flit, a clock after the pop
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credit_q <= 1'b0;
    end else begin
      credit_q <= pop_i;
    end
  end

  assign head_o   = mem_q[rd_ptr_q];
  assign head_v_o = (count_q != '0);
  assign credit_o = credit_q;

endmodule

//--- hw/wh_io_fabric.sv
`timescale 1ns/100ps

module wh_io_fabric (
  input  logic             clk_i,
  input  logic             rst_n_i,

  input  wh_pkg::wh_link_t north_link_i,
  output logic             north_credit_o,
  input  wh_pkg::wh_link_t south_link_i,
  output logic             south_credit_o,

  output wh_pkg::wh_link_t mem_north_link_o,
  input  logic             mem_north_credit_i,
  output wh_pkg::wh_link_t mem_south_link_o,
  input  logic             mem_south_credit_i,

  output wh_pkg::wh_link_t io_link_o,
  input  logic             io_credit_i
);
  import wh_pkg::*;

  // router local ports into the concentrator, north is 0
  wh_link_t [1:0] local_link;
  logic [1:0]     local_credit;

  wh_router rtr_north (
    .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.link_i(north_link_i)
    ,.credit_o(north_credit_o)
    ,.mem_link_o(mem_north_link_o)
    ,.mem_credit_i(mem_north_credit_i)
    ,.local_link_o(local_link[0])
    ,.local_credit_i(local_credit[0])
  );

  wh_router rtr_south (
    .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.link_i(south_link_i)
    ,.credit_o(south_credit_o)
    ,.mem_link_o(mem_south_link_o)
    ,.mem_credit_i(mem_south_credit_i)
    ,.local_link_o(local_link[1])
    ,.local_credit_i(local_credit[1])
  );

  wh_concentrator ctr (
    .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.link_i(local_link)
    ,.credit_o(local_credit)
    ,.io_link_o(io_link_o)
    ,.io_credit_i(io_credit_i)
  );

endmodule

//--- hw/wh_pkg.sv
package wh_pkg;

  // flit and header field widths
  localparam int WH_FLIT_W    = 32;
  localparam int WH_CORD_W    = 4;
  localparam int WH_LEN_W     = 3;
  localparam int WH_CID_W     = 1;
  localparam int WH_PAYLOAD_W = WH_FLIT_W - WH_CID_W - WH_LEN_W - WH_CORD_W;

  // receive buffer, also the initial credit count of each sender
  localparam int WH_FIFO_DEPTH = 4;
  localparam int WH_PTR_W      = $clog2(WH_FIFO_DEPTH);
  localparam int WH_CNT_W      = $clog2(WH_FIFO_DEPTH + 1);

  typedef logic [WH_FLIT_W-1:0] wh_flit_t;
  typedef logic [WH_CORD_W-1:0] wh_cord_t;
  typedef logic [WH_LEN_W-1:0]  wh_len_t;   // body flits after the header
  typedef logic [WH_CID_W-1:0]  wh_cid_t;
  typedef logic [WH_PTR_W-1:0]  wh_ptr_t;
  typedef logic [WH_CNT_W-1:0]  wh_credit_cnt_t;

  // packets to this cord leave on the local port
  localparam wh_cord_t WH_IO_CORD = 4'hF;

  typedef struct packed {
    logic [WH_PAYLOAD_W-1:0] payload;
    wh_cid_t                 cid;
    wh_len_t                 len;
    wh_cord_t                cord;    // low bits
  } wh_header_t;

  typedef struct packed {
    logic     v;
    wh_flit_t data;
  } wh_link_t;

  typedef enum logic {
    WH_IDLE,
    WH_BODY
  } wh_route_state_e;

endpackage

//--- hw/wh_router.sv
`timescale 1ns/100ps

module wh_router (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  wh_pkg::wh_link_t link_i,
  output logic             credit_o,
  output wh_pkg::wh_link_t mem_link_o,
  input  logic             mem_credit_i,
  output wh_pkg::wh_link_t local_link_o,
  input  logic             local_credit_i
);
  import wh_pkg::*;

  wh_flit_t             head;
  logic                 head_v;
  logic                 pop;
  wh_header_t           hdr;
  wh_route_state_e      state_q;
  logic                 local_q;     // path held for the packet body
  wh_len_t              body_cnt_q;
  logic                 sel_local;
  wh_credit_cnt_t [1:0] cnt_q;       // [0] memory, [1] local
  logic [1:0]           cred_ret;
  logic [1:0]           spend;
  logic [1:0]           out_v_q;
  wh_flit_t             out_q;

  wh_credit_fifo fifo (
    .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.link_i(link_i)
    ,.credit_o(credit_o)
    ,.head_o(head)
    ,.head_v_o(head_v)
    ,.pop_i(pop)
  );

  assign hdr       = wh_header_t'(head);
  assign sel_local = (state_q == WH_IDLE) ? (hdr.cord == WH_IO_CORD) : local_q;
  assign pop       = head_v && (cnt_q[sel_local] != '0);
  assign spend     = {pop & sel_local, pop & ~sel_local};
  assign cred_ret  = {local_credit_i, mem_credit_i};

  // header decode picks the path, body counter releases it
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= WH_IDLE;
      local_q    <= 1'b0;
      body_cnt_q <= '0;
    end else if (pop) begin
      if (state_q == WH_IDLE) begin
        local_q    <= sel_local;
        body_cnt_q <= hdr.len;
        if (hdr.len != '0) begin
          state_q <= WH_BODY;
        end
      end else begin
        body_cnt_q <= body_cnt_q - 1'b1;
        if (body_cnt_q == wh_len_t'(1)) begin
          state_q <= WH_IDLE;  // last body flit
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= {2{wh_credit_cnt_t'(WH_FIFO_DEPTH)}};
    end else begin
      for (int i = 0; i < 2; i++) begin
        cnt_q[i] <= cnt_q[i] + wh_credit_cnt_t'(cred_ret[i]) - wh_credit_cnt_t'(spend[i]);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_v_q <= '0;
    end else begin
      out_v_q <= spend;
    end
  end

  // one data register serves both outputs
  always_ff @(posedge clk_i) begin
    if (pop) begin
      out_q <= head;
    end
  end

  assign mem_link_o.v      = out_v_q[0];
  assign mem_link_o.data   = out_q;
  assign local_link_o.v    = out_v_q[1];
  assign local_link_o.data = out_q;

endmodule

//--- wh_io_fabric.f
hw/wh_pkg.sv
hw/wh_credit_fifo.sv
hw/wh_router.sv
hw/wh_concentrator.sv
hw/wh_io_fabric.sv
dv/wh_clk_gen.sv
dv/wh_io_fabric_props.sv
dv/wh_io_fabric_tb.sv
